//--- common/rename_pkg.sv
`default_nettype none

package rename_pkg;

    localparam int NUM_ARCH   = 32;
    localparam int NUM_PREGS  = 64;
    localparam int FREE_DEPTH = NUM_PREGS - NUM_ARCH;
    localparam int FREE_IDX_W = $clog2(FREE_DEPTH);

    typedef logic [4:0] arch_reg_t;
    typedef logic [7:0] preg_t;
    typedef logic [6:0] opcode_t;

    // Sentinels sit above the physical tag range
    localparam preg_t NO_SRC = 8'hFE;
    localparam preg_t NO_DST = 8'hFF;

    // RV32I major opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;

    typedef struct packed {
        opcode_t   opcode;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } rename_req_t;

    typedef struct packed {
        preg_t ps1;
        preg_t ps2;
        preg_t pd;
        preg_t old_pd;
        logic  no_tag;
    } rename_resp_t;

    // Whole map, entry k holds the tag of register k
    typedef preg_t [NUM_ARCH-1:0] map_snapshot_t;

    // Index bits plus one wrap bit
    typedef logic [FREE_IDX_W:0] free_ptr_t;

    function automatic logic uses_rs1(opcode_t op);
        return !(op inside {OP_LUI, OP_AUIPC, OP_JAL});
    endfunction

    function automatic logic uses_rs2(opcode_t op);
        return !(op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM});
    endfunction

    // x0 is never renamed
    function automatic logic writes_rd(opcode_t op, arch_reg_t rd);
        logic no_dest_op;
        no_dest_op = op inside {OP_BRANCH, OP_STORE, 7'b0000000};
        return !no_dest_op && (rd != 5'd0);
    endfunction

endpackage

`default_nettype wire

//--- hw/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list #(
    parameter int NUM_PAGES = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         flush,
    input  wire logic                         alloc,
    input  wire logic                         release_valid,
    input  wire rename_pkg::preg_t            release_tag,
    input  wire logic                         save,
    input  wire logic [$clog2(NUM_PAGES)-1:0] save_page,
    input  wire logic                         restore,
    input  wire logic [$clog2(NUM_PAGES)-1:0] restore_page,
    output rename_pkg::preg_t                 alloc_tag,
    output logic                              free_empty
);

    import rename_pkg::*;

    // Full at reset, tail one lap ahead of head
    localparam free_ptr_t HEAD_INIT = '0;
    localparam free_ptr_t TAIL_INIT = {1'b1, {FREE_IDX_W{1'b0}}};

    preg_t     fifo [FREE_DEPTH];
    free_ptr_t head_q;
    free_ptr_t tail_q;
    free_ptr_t snap_head;
    free_ptr_t work_head;
    logic      snap_wr;

    assign snap_wr = save && !restore && !flush;

    // Popped entries stay in the buffer, so moving head back frees them again
    assign work_head = restore ? snap_head : head_q;

    assign free_empty = (work_head == tail_q);
    assign alloc_tag  = fifo[work_head[FREE_IDX_W-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= HEAD_INIT;
        end else if (flush) begin
            head_q <= HEAD_INIT;
        end else if (alloc) begin
            head_q <= work_head + 1'b1;
        end else begin
            head_q <= work_head;
        end
    end

    // Release still lands during a restore, not during a flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_q <= TAIL_INIT;
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo[i] <= preg_t'(NUM_ARCH + i);
            end
        end else if (flush) begin
            tail_q <= TAIL_INIT;
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo[i] <= preg_t'(NUM_ARCH + i);
            end
        end else if (release_valid) begin
            fifo[tail_q[FREE_IDX_W-1:0]] <= release_tag;
            tail_q                       <= tail_q + 1'b1;
        end
    end

    // Head from before this cycle's pop
    rename_checkpoints #(
        .NUM_PAGES (NUM_PAGES),
        .payload_t (free_ptr_t)
    ) u_pages (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (snap_wr),
        .wr_page (save_page),
        .wr_data (head_q),
        .rd_page (restore_page),
        .rd_data (snap_head)
    );

endmodule

`default_nettype wire

//--- hw/rename_checkpoints.sv
`timescale 1ns/1ns
`default_nettype none

module rename_checkpoints #(
    parameter int  NUM_PAGES = 8,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         wr,
    input  wire logic [$clog2(NUM_PAGES)-1:0] wr_page,
    input  wire payload_t                     wr_data,
    input  wire logic [$clog2(NUM_PAGES)-1:0] rd_page,
    output payload_t                          rd_data
);

    payload_t pages [NUM_PAGES];

    // One page written per cycle at most
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PAGES; p++) begin
                pages[p] <= '0;
            end
        end else if (wr) begin
            pages[wr_page] <= wr_data;
        end
    end

    // Restore needs the page in the same cycle
    assign rd_data = pages[rd_page];

endmodule

`default_nettype wire

//--- hw/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module rename_stage #(
    parameter int NUM_PAGES = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,

    input  wire logic                         req_valid,
    input  wire rename_pkg::rename_req_t      req,

    input  wire logic                         save,
    input  wire logic [$clog2(NUM_PAGES)-1:0] save_page,
    input  wire logic                         restore,
    input  wire logic [$clog2(NUM_PAGES)-1:0] restore_page,
    input  wire logic                         flush,

    // Tags handed back by commit
    input  wire logic                         release_valid,
    input  wire rename_pkg::preg_t            release_tag,

    output logic                              resp_valid,
    output rename_pkg::rename_resp_t          resp,
    output logic                              free_empty
);

    import rename_pkg::*;

    logic  alloc;
    preg_t alloc_tag;

    rename_map #(
        .NUM_PAGES (NUM_PAGES)
    ) u_map (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .req_valid    (req_valid),
        .req          (req),
        .save         (save),
        .save_page    (save_page),
        .restore      (restore),
        .restore_page (restore_page),
        .alloc_tag    (alloc_tag),
        .free_empty   (free_empty),
        .alloc        (alloc),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

    free_list #(
        .NUM_PAGES (NUM_PAGES)
    ) u_free (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .alloc         (alloc),
        .release_valid (release_valid),
        .release_tag   (release_tag),
        .save          (save),
        .save_page     (save_page),
        .restore       (restore),
        .restore_page  (restore_page),
        .alloc_tag     (alloc_tag),
        .free_empty    (free_empty)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+sim
common/rename_pkg.sv
hw/rename_checkpoints.sv
rat/rename_map.sv
hw/free_list.sv
hw/rename_stage.sv
sim/tb_rename_stage.sv

//--- rat/rename_map.sv
`timescale 1ns/1ns
`default_nettype none

module rename_map #(
    parameter int NUM_PAGES = 8
) (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         flush,
    input  wire logic                         req_valid,
    input  wire rename_pkg::rename_req_t      req,
    input  wire logic                         save,
    input  wire logic [$clog2(NUM_PAGES)-1:0] save_page,
    input  wire logic                         restore,
    input  wire logic [$clog2(NUM_PAGES)-1:0] restore_page,
    input  wire rename_pkg::preg_t            alloc_tag,
    input  wire logic                         free_empty,
    output logic                              alloc,
    output logic                              resp_valid,
    output rename_pkg::rename_resp_t          resp
);

    import rename_pkg::*;

    function automatic map_snapshot_t identity_map();
        map_snapshot_t m;
        for (int k = 0; k < NUM_ARCH; k++) begin
            m[k] = preg_t'(k);
        end
        return m;
    endfunction

    localparam map_snapshot_t RESET_MAP = identity_map();

    map_snapshot_t map_q;
    map_snapshot_t map_d;
    map_snapshot_t snap_map;
    map_snapshot_t work_map;
    rename_resp_t  resp_d;
    logic          dst_wanted;
    logic          snap_wr;

    // Save is dropped when a restore or flush arrives with it
    assign snap_wr = save && !restore && !flush;

    // Restored map is visible to this cycle's rename
    assign work_map = restore ? snap_map : map_q;

    assign dst_wanted = req_valid && writes_rd(req.opcode, req.rd);
    assign alloc      = dst_wanted && !free_empty && !flush;

    always_comb begin
        resp_d.ps1    = uses_rs1(req.opcode) ? work_map[req.rs1] : NO_SRC;
        resp_d.ps2    = uses_rs2(req.opcode) ? work_map[req.rs2] : NO_SRC;
        resp_d.pd     = NO_DST;
        resp_d.old_pd = NO_DST;
        resp_d.no_tag = 1'b0;
        if (writes_rd(req.opcode, req.rd)) begin
            if (free_empty) begin
                // Caller ignored free_empty, nothing renamed
                resp_d.no_tag = 1'b1;
            end else begin
                resp_d.pd     = alloc_tag;
                resp_d.old_pd = work_map[req.rd];
            end
        end
    end

    always_comb begin
        map_d = work_map;
        if (alloc) begin
            map_d[req.rd] = alloc_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_q      <= RESET_MAP;
            resp_valid <= 1'b0;
        end else if (flush) begin
            map_q      <= RESET_MAP;
            resp_valid <= 1'b0;
        end else begin
            map_q      <= map_d;
            resp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp <= resp_d;
        end
    end

    // Snapshot holds the map from before this cycle's remap
    rename_checkpoints #(
        .NUM_PAGES (NUM_PAGES),
        .payload_t (map_snapshot_t)
    ) u_pages (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (snap_wr),
        .wr_page (save_page),
        .wr_data (map_q),
        .rd_page (restore_page),
        .rd_data (snap_map)
    );

endmodule

`default_nettype wire

//--- sim/rename_ref.svh
`ifndef RENAME_REF_SVH
`define RENAME_REF_SVH

// Expected rename state
map_snapshot_t ref_map;
// Every tag pushed into the free list since the last flush
preg_t         ref_hist [$];
int            ref_head;
map_snapshot_t ref_page_map [TB_PAGES];
int            ref_page_head [TB_PAGES];
bit            ref_page_ok [TB_PAGES];

function automatic void reset_model();
    for (int k = 0; k < NUM_ARCH; k++) begin
        ref_map[k] = preg_t'(k);
    end
    ref_hist.delete();
    for (int i = 0; i < FREE_DEPTH; i++) begin
        ref_hist.push_back(preg_t'(NUM_ARCH + i));
    end
    ref_head = 0;
    for (int p = 0; p < TB_PAGES; p++) begin
        ref_page_ok[p] = 1'b0;
    end
endfunction

function automatic void classify_opcode(input opcode_t op, input arch_reg_t rd,
                                        output bit r1, output bit r2, output bit wr);
    r1 = 1'b1;
    r2 = 1'b1;
    wr = (rd != 5'd0);
    case (op)
        OPC_LUI, OPC_AUIPC, OPC_JAL: begin
            r1 = 1'b0;
            r2 = 1'b0;
        end
        OPC_JALR, OPC_LOAD, OPC_IMM: r2 = 1'b0;
        OPC_BRANCH, OPC_STORE, 7'd0: wr = 1'b0;
        default: ;
    endcase
endfunction

function automatic bit expected_empty(input logic restore, input page_t page);
    int h;
    h = restore ? ref_page_head[page] : ref_head;
    return h == ref_hist.size();
endfunction

// A release may not overwrite a tag that some live page could still hand out
function automatic bit has_release_room();
    int oldest;
    oldest = ref_head;
    for (int p = 0; p < TB_PAGES; p++) begin
        if (ref_page_ok[p] && ref_page_head[p] < oldest) begin
            oldest = ref_page_head[p];
        end
    end
    return (ref_hist.size() - oldest) < FREE_DEPTH;
endfunction

function automatic rename_resp_t step_model(input logic rv, input rename_req_t r,
                                            input ctl_t c);
    rename_resp_t  res;
    map_snapshot_t work;
    int            work_head;
    bit            r1;
    bit            r2;
    bit            wr;
    res.ps1    = NO_SRC;
    res.ps2    = NO_SRC;
    res.pd     = NO_DST;
    res.old_pd = NO_DST;
    res.no_tag = 1'b0;
    if (c.flush) begin
        reset_model();
        return res;
    end
    work      = c.restore ? ref_page_map[c.restore_page] : ref_map;
    work_head = c.restore ? ref_page_head[c.restore_page] : ref_head;
    classify_opcode(r.opcode, r.rd, r1, r2, wr);
    if (r1) begin
        res.ps1 = work[r.rs1];
    end
    if (r2) begin
        res.ps2 = work[r.rs2];
    end
    if (rv && wr && work_head == ref_hist.size()) begin
        res.no_tag = 1'b1;
    end else if (rv && wr) begin
        res.pd        = ref_hist[work_head];
        res.old_pd    = work[r.rd];
        work[r.rd]    = res.pd;
        work_head     = work_head + 1;
    end
    if (c.save && !c.restore) begin
        ref_page_map[c.save_page]  = ref_map;
        ref_page_head[c.save_page] = ref_head;
        ref_page_ok[c.save_page]   = 1'b1;
    end
    ref_map  = work;
    ref_head = work_head;
    if (c.release_valid) begin
        ref_hist.push_back(c.release_tag);
    end
    return res;
endfunction

`endif

//--- sim/tb_rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rename_stage;

    import rename_pkg::*;

    localparam int TB_PAGES        = 8;
    localparam int PAGE_W          = $clog2(TB_PAGES);
    localparam int RESET_CYCLES    = 4;
    localparam int DIRECTED_CYCLES = 120;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int DRAIN_CYCLES    = 4;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int WATCHDOG_NS     = TOTAL_CYCLES * 10 * 2;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_IMM    = 7'b0010011;
    localparam opcode_t OPC_R      = 7'b0110011;

    typedef logic [PAGE_W-1:0] page_t;

    typedef struct packed {
        logic  save;
        page_t save_page;
        logic  restore;
        page_t restore_page;
        logic  flush;
        logic  release_valid;
        preg_t release_tag;
    } ctl_t;

    typedef struct packed {
        logic         valid;
        rename_resp_t resp;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         req_valid;
    rename_req_t  req;
    ctl_t         ctl;
    ctl_t         ctl_next;
    logic         resp_valid;
    rename_resp_t resp;
    logic         free_empty;

    expect_t      exp_q [$];
    expect_t      exp_now;
    preg_t        commit_q [$];
    int           seed = 24;
    int           value_errors = 0;
    int           missing_errors = 0;
    int           extra_errors = 0;

    `include "rename_ref.svh"

    rename_stage #(
        .NUM_PAGES (TB_PAGES)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .save          (ctl.save),
        .save_page     (ctl.save_page),
        .restore       (ctl.restore),
        .restore_page  (ctl.restore_page),
        .flush         (ctl.flush),
        .release_valid (ctl.release_valid),
        .release_tag   (ctl.release_tag),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .free_empty    (free_empty)
    );

    always #5 clk = ~clk;

    task automatic check_resp(input string name, input rename_resp_t exp, input rename_resp_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input preg_t exp, input preg_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    function automatic opcode_t opcode_at(input int i);
        case (i)
            0: return OPC_LUI;
            1: return OPC_AUIPC;
            2: return OPC_JAL;
            3: return OPC_JALR;
            4: return OPC_BRANCH;
            5: return OPC_LOAD;
            6: return OPC_STORE;
            7: return OPC_IMM;
            8: return OPC_R;
            default: return 7'd0;
        endcase
    endfunction

    // One cycle of stimulus driven on the falling edge
    task automatic tick(input logic rv, input rename_req_t r);
        expect_t e;
        logic    exp_empty;
        @(negedge clk);
        req_valid = rv;
        req       = r;
        ctl       = ctl_next;
        exp_empty = expected_empty(ctl_next.restore, ctl_next.restore_page);
        e.valid   = rv && !ctl_next.flush;
        e.resp    = step_model(rv, r, ctl_next);
        exp_q.push_back(e);
        if (ctl_next.flush) begin
            commit_q.delete();
        end else if (e.valid && e.resp.old_pd != NO_DST) begin
            commit_q.push_back(e.resp.old_pd);
        end
        ctl_next = '0;
        #1;
        check_tag("free_empty", preg_t'(exp_empty), preg_t'(free_empty));
    endtask

    task automatic rename(input opcode_t op, input arch_reg_t rs1, input arch_reg_t rs2,
                          input arch_reg_t rd);
        rename_req_t r;
        r.opcode = op;
        r.rs1    = rs1;
        r.rs2    = rs2;
        r.rd     = rd;
        tick(1'b1, r);
    endtask

    task automatic idle();
        tick(1'b0, '0);
    endtask

    task automatic hand_back(input preg_t tag);
        ctl_next.release_valid = 1'b1;
        ctl_next.release_tag   = tag;
        idle();
    endtask

    task automatic wait_resp();
        @(posedge clk);
        #1;
    endtask

    task automatic random_cycle();
        rename_req_t r;
        logic        rv;
        int          pick;
        page_t       pg;
        r.opcode = opcode_at($unsigned($random(seed)) % 10);
        r.rs1    = arch_reg_t'($random(seed));
        r.rs2    = arch_reg_t'($random(seed));
        r.rd     = arch_reg_t'($random(seed));
        rv       = ($unsigned($random(seed)) % 4) != 0;
        pick     = $unsigned($random(seed)) % 128;
        pg       = page_t'($random(seed));
        if (pick < 12) begin
            ctl_next.save      = 1'b1;
            ctl_next.save_page = pg;
        end else if (pick < 18 && ref_page_ok[pg]) begin
            ctl_next.restore      = 1'b1;
            ctl_next.restore_page = pg;
            ctl_next.save         = (pick < 14);
            ctl_next.save_page    = pg + 1'b1;
        end else if (pick == 18) begin
            ctl_next.flush = 1'b1;
        end else if (pick > 18 && pick < 27) begin
            // Resolved branch frees its page for reuse
            ref_page_ok[pg] = 1'b0;
        end
        if (commit_q.size() > 0 && ($random(seed) % 2) == 0 && has_release_room()) begin
            ctl_next.release_valid = 1'b1;
            ctl_next.release_tag   = commit_q.pop_front();
        end
        tick(rv, r);
    endtask

    // Response check one cycle after each request
    always begin
        @(posedge clk);
        #1;
        if (exp_q.size() == 0) begin
            if (resp_valid === 1'b1) begin
                extra_errors++;
                $display("unexpected response at %0t with no request before it", $time);
            end
        end else begin
            exp_now = exp_q.pop_front();
            if (exp_now.valid && resp_valid !== 1'b1) begin
                missing_errors++;
                $display("missing response at %0t for the request one cycle earlier", $time);
            end else if (!exp_now.valid && resp_valid !== 1'b0) begin
                extra_errors++;
                $display("unexpected response at %0t", $time);
            end else if (exp_now.valid) begin
                check_resp("resp", exp_now.resp, resp);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        ctl       = '0;
        ctl_next  = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Identity map after reset and no allocation for non-writers
        rename(OPC_R, 5'd5, 5'd7, 5'd0);
        wait_resp();
        check_tag("resp.ps1", 8'd5, resp.ps1);
        check_tag("resp.ps2", 8'd7, resp.ps2);
        check_tag("resp.pd", NO_DST, resp.pd);
        rename(OPC_STORE, 5'd3, 5'd4, 5'd9);
        wait_resp();
        check_tag("resp.pd", NO_DST, resp.pd);
        rename(OPC_BRANCH, 5'd1, 5'd2, 5'd10);
        rename(OPC_IMM, 5'd1, 5'd0, 5'd1);
        wait_resp();
        check_tag("resp.pd", 8'd32, resp.pd);
        check_tag("resp.old_pd", 8'd1, resp.old_pd);

        // Tags come out in order and readers see the new mapping
        rename(OPC_IMM, 5'd0, 5'd0, 5'd2);
        wait_resp();
        check_tag("resp.pd", 8'd33, resp.pd);
        rename(OPC_R, 5'd4, 5'd5, 5'd3);
        wait_resp();
        check_tag("resp.old_pd", 8'd3, resp.old_pd);
        rename(OPC_R, 5'd2, 5'd3, 5'd0);
        wait_resp();
        check_tag("resp.ps1", 8'd33, resp.ps1);
        check_tag("resp.ps2", 8'd34, resp.ps2);

        // Operand use by opcode class
        rename(OPC_LUI, 5'd6, 5'd7, 5'd8);
        wait_resp();
        check_tag("resp.ps1", NO_SRC, resp.ps1);
        check_tag("resp.ps2", NO_SRC, resp.ps2);
        rename(OPC_LOAD, 5'd6, 5'd7, 5'd9);
        wait_resp();
        check_tag("resp.ps1", 8'd6, resp.ps1);
        check_tag("resp.ps2", NO_SRC, resp.ps2);
        for (int i = 0; i < 10; i++) begin
            rename(opcode_at(i), 5'd6, 5'd7, 5'd10);
        end

        // Drain the free list, then refill through commit
        ctl_next.flush = 1'b1;
        idle();
        for (int i = 0; i < FREE_DEPTH; i++) begin
            rename(OPC_R, 5'd1, 5'd2, arch_reg_t'(i % 31 + 1));
        end
        idle();
        check_tag("free_empty", 8'd1, preg_t'(free_empty));
        rename(OPC_R, 5'd1, 5'd2, 5'd3);
        wait_resp();
        check_tag("resp.no_tag", 8'd1, preg_t'(resp.no_tag));
        check_tag("resp.pd", NO_DST, resp.pd);
        hand_back(8'd5);
        hand_back(8'd9);
        hand_back(8'd17);
        rename(OPC_IMM, 5'd1, 5'd0, 5'd4);
        wait_resp();
        check_tag("resp.pd", 8'd5, resp.pd);
        rename(OPC_IMM, 5'd1, 5'd0, 5'd5);
        wait_resp();
        check_tag("resp.pd", 8'd9, resp.pd);
        rename(OPC_IMM, 5'd1, 5'd0, 5'd6);
        wait_resp();
        check_tag("resp.pd", 8'd17, resp.pd);

        // Checkpoint, speculate, then roll back with a reader in the same cycle
        ctl_next.flush = 1'b1;
        idle();
        ctl_next.save      = 1'b1;
        ctl_next.save_page = 3'd3;
        rename(OPC_IMM, 5'd0, 5'd0, 5'd1);
        rename(OPC_IMM, 5'd0, 5'd0, 5'd2);
        rename(OPC_IMM, 5'd0, 5'd0, 5'd3);
        ctl_next.restore      = 1'b1;
        ctl_next.restore_page = 3'd3;
        rename(OPC_R, 5'd1, 5'd2, 5'd0);
        wait_resp();
        check_tag("resp.ps1", 8'd1, resp.ps1);
        check_tag("resp.ps2", 8'd2, resp.ps2);
        rename(OPC_IMM, 5'd0, 5'd0, 5'd4);
        wait_resp();
        check_tag("resp.pd", 8'd32, resp.pd);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_cycle();
        end
        repeat (DRAIN_CYCLES) idle();
        @(posedge clk);
        #2;
        $display("errors: value %0d, missing %0d, unexpected %0d",
                 value_errors, missing_errors, extra_errors);
        if (value_errors + missing_errors + extra_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
